// File: include/udp_echo_settings.svh
// --------------------------------------
// Echo port and buffer sizes; FIFO depths must be powers of two
// --------------------------------------
`ifndef UDP_ECHO_SETTINGS_SVH
`define UDP_ECHO_SETTINGS_SVH

// Destination port that gets echoed
`define UDP_ECHO_PORT 16'd1234

// Payload byte width
`define UDP_DATA_W 8

// Reply headers waiting at once
`define HDR_FIFO_DEPTH 4

// Payload beats, kept small for simulation
`define PAYLOAD_FIFO_DEPTH 64

`endif

// File: hw/net_types_pkg.sv
// --------------------------------------
// UDP/IPv4 header fields used by the echo path
// --------------------------------------
package net_types_pkg;

    // IPv4 address
    typedef logic [31:0] ip_addr_t;

    // UDP port number
    typedef logic [15:0] udp_port_t;

    // UDP length field, header plus payload in bytes
    typedef logic [15:0] udp_len_t;

    // Reply header handed to the downstream stack
    // DSCP, TTL, checksum and source IP are filled in there
    typedef struct packed {
        ip_addr_t  dest_ip;
        udp_port_t src_port;
        udp_port_t dest_port;
        udp_len_t  length;
    } udp_reply_hdr_t;

endpackage

// File: hw/stream_pkg.sv
// --------------------------------------
// Payload beat, one byte per transfer
// --------------------------------------
package stream_pkg;

    `include "udp_echo_settings.svh"

    // user marks a bad frame, as in the MAC stream
    typedef struct packed {
        logic [`UDP_DATA_W-1:0] data;
        logic                   last;
        logic                   user;
    } payload_beat_t;

endpackage

// File: hw/stream_if.sv
// --------------------------------------
// Valid/ready link; data holds while valid waits for ready
// --------------------------------------
`timescale 1ns/1ps

interface stream_if #(
    parameter type T = logic
);

    logic valid;
    logic ready;
    T     data;

    // Producer side
    modport src (
        output valid,
        output data,
        input  ready
    );

    // Consumer side
    modport snk (
        input  valid,
        input  data,
        output ready
    );

endinterface

// File: hw/stream_fifo.sv
// --------------------------------------
// Synchronous FIFO, DEPTH a power of two and at least 2
// Item readable one cycle after it is written
// --------------------------------------
`timescale 1ns/1ps

module stream_fifo #(
    parameter type T     = logic,
    parameter int  DEPTH = 4
) (
    input  logic  clk,
    input  logic  rst,
    stream_if.snk s_in,
    stream_if.src s_out
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_en;
    logic             rd_en;

    assign s_in.ready  = (count != CNT_W'(DEPTH));
    assign s_out.valid = (count != '0);
    assign s_out.data  = mem[rd_ptr];

    assign wr_en = s_in.valid && s_in.ready;
    assign rd_en = s_out.valid && s_out.ready;

    // Storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= s_in.data;
        end
    end

    // Pointers wrap on their own since DEPTH is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Item refused while full is offered again, unchanged
    a_in_hold: assert property (@(posedge clk) disable iff (rst)
        s_in.valid && !s_in.ready |=> s_in.valid && $stable(s_in.data));

    // Stalled head stays put until it is read
    a_out_hold: assert property (@(posedge clk) disable iff (rst)
        s_out.valid && !s_out.ready |=> s_out.valid && $stable(s_out.data));

endmodule

// File: hw/udp_rx_filter.sv
// --------------------------------------
// Each header must be followed by one payload ending in last
// --------------------------------------
`timescale 1ns/1ps

`include "udp_echo_settings.svh"

module udp_rx_filter
    import net_types_pkg::*;
    import stream_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          i_hdr_valid,
    output logic          o_hdr_ready,
    input  ip_addr_t      i_src_ip,
    // Not part of the reply; downstream sets the source IP
    input  ip_addr_t      i_dest_ip,
    input  udp_port_t     i_src_port,
    input  udp_port_t     i_dest_port,
    input  udp_len_t      i_length,
    input  logic          i_tvalid,
    output logic          o_tready,
    input  payload_beat_t i_beat,
    stream_if.src         hdr_q,
    stream_if.src         pay_q
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PASS,
        ST_DROP
    } state_t;

    state_t state;
    logic   match;
    logic   hdr_fire;
    logic   beat_fire;

    assign match = (i_dest_port == `UDP_ECHO_PORT);

    // Header side, only open between frames
    assign hdr_q.valid = (state == ST_IDLE) && i_hdr_valid && match;
    assign o_hdr_ready = (state == ST_IDLE) && (match ? hdr_q.ready : 1'b1);

    // Reply goes back to the sender with ports swapped
    assign hdr_q.data.dest_ip   = i_src_ip;
    assign hdr_q.data.src_port  = i_dest_port;
    assign hdr_q.data.dest_port = i_src_port;
    assign hdr_q.data.length    = i_length;

    // Payload side
    assign pay_q.valid = (state == ST_PASS) && i_tvalid;
    assign pay_q.data  = i_beat;
    // Dropped frames drain at full rate
    assign o_tready = ((state == ST_PASS) && pay_q.ready) || (state == ST_DROP);

    assign hdr_fire  = i_hdr_valid && o_hdr_ready;
    assign beat_fire = i_tvalid && o_tready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (hdr_fire) begin
                        state <= match ? ST_PASS : ST_DROP;
                    end
                end
                ST_PASS, ST_DROP: begin
                    if (beat_fire && i_beat.last) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Accepted header opens a frame, so no second header until its last beat
    a_hdr_only_idle: assert property (@(posedge clk) disable iff (rst)
        hdr_fire |=> (state != ST_IDLE) && !hdr_fire);

    // Beats belong to a frame whose header was already taken
    a_no_beat_idle: assert property (@(posedge clk) disable iff (rst)
        beat_fire |-> (state != ST_IDLE) && $past(state != ST_IDLE || hdr_fire));

endmodule

// File: hw/udp_tx_sequencer.sv
// --------------------------------------
// One reply header, then its payload up to the last beat
// --------------------------------------
`timescale 1ns/1ps

module udp_tx_sequencer
    import net_types_pkg::*;
    import stream_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    stream_if.snk         hdr_q,
    stream_if.snk         pay_q,
    output logic          o_hdr_valid,
    input  logic          i_hdr_ready,
    output ip_addr_t      o_dest_ip,
    output udp_port_t     o_src_port,
    output udp_port_t     o_dest_port,
    output udp_len_t      o_length,
    output logic          o_tvalid,
    input  logic          i_tready,
    output payload_beat_t o_beat
);

    typedef enum logic {
        ST_HDR,
        ST_PAY
    } state_t;

    state_t state;
    logic   hdr_fire;
    logic   beat_fire;

    // Header straight from the queue head
    assign o_hdr_valid = (state == ST_HDR) && hdr_q.valid;
    assign hdr_q.ready = (state == ST_HDR) && i_hdr_ready;
    assign o_dest_ip   = hdr_q.data.dest_ip;
    assign o_src_port  = hdr_q.data.src_port;
    assign o_dest_port = hdr_q.data.dest_port;
    assign o_length    = hdr_q.data.length;

    // Payload only once the header has gone
    assign o_tvalid    = (state == ST_PAY) && pay_q.valid;
    assign pay_q.ready = (state == ST_PAY) && i_tready;
    assign o_beat      = pay_q.data;

    assign hdr_fire  = o_hdr_valid && i_hdr_ready;
    assign beat_fire = o_tvalid && i_tready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_HDR;
        end else begin
            case (state)
                ST_HDR: begin
                    if (hdr_fire) begin
                        state <= ST_PAY;
                    end
                end
                ST_PAY: begin
                    if (beat_fire && o_beat.last) begin
                        state <= ST_HDR;
                    end
                end
                default: state <= ST_HDR;
            endcase
        end
    end

    // Waiting beats between frames always have their header queued ahead
    a_pay_after_hdr: assert property (@(posedge clk) disable iff (rst)
        (state == ST_HDR) && pay_q.valid |-> hdr_q.valid);

    // Stalled beat stays put, which relies on the FIFO holding its head
    a_beat_hold: assert property (@(posedge clk) disable iff (rst)
        o_tvalid && !i_tready |=> o_tvalid && $stable(o_beat));

endmodule

// File: hw/udp_echo_top.sv
// --------------------------------------
// UDP echo at frame level; replies need downstream IP fill-in
// --------------------------------------
`timescale 1ns/1ps

`include "udp_echo_settings.svh"

module udp_echo_top
    import net_types_pkg::*;
    import stream_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,

    // Receive header
    input  logic                   i_rx_hdr_valid,
    output logic                   o_rx_hdr_ready,
    input  ip_addr_t               i_rx_src_ip,
    input  ip_addr_t               i_rx_dest_ip,
    input  udp_port_t              i_rx_src_port,
    input  udp_port_t              i_rx_dest_port,
    input  udp_len_t               i_rx_length,

    // Receive payload
    input  logic                   i_rx_tvalid,
    output logic                   o_rx_tready,
    input  logic [`UDP_DATA_W-1:0] i_rx_tdata,
    input  logic                   i_rx_tlast,
    input  logic                   i_rx_tuser,

    // Transmit header
    output logic                   o_tx_hdr_valid,
    input  logic                   i_tx_hdr_ready,
    output ip_addr_t               o_tx_dest_ip,
    output udp_port_t              o_tx_src_port,
    output udp_port_t              o_tx_dest_port,
    output udp_len_t               o_tx_length,

    // Transmit payload
    output logic                   o_tx_tvalid,
    input  logic                   i_tx_tready,
    output logic [`UDP_DATA_W-1:0] o_tx_tdata,
    output logic                   o_tx_tlast,
    output logic                   o_tx_tuser
);

    payload_beat_t rx_beat;
    payload_beat_t tx_beat;

    // Index 0 feeds a FIFO, index 1 drains it
    stream_if #(.T(udp_reply_hdr_t)) hdr_q [2] ();
    stream_if #(.T(payload_beat_t))  pay_q [2] ();

    assign rx_beat.data = i_rx_tdata;
    assign rx_beat.last = i_rx_tlast;
    assign rx_beat.user = i_rx_tuser;

    assign o_tx_tdata = tx_beat.data;
    assign o_tx_tlast = tx_beat.last;
    assign o_tx_tuser = tx_beat.user;

    udp_rx_filter rx_filter_i (
        .clk         (clk),
        .rst         (rst),
        .i_hdr_valid (i_rx_hdr_valid),
        .o_hdr_ready (o_rx_hdr_ready),
        .i_src_ip    (i_rx_src_ip),
        .i_dest_ip   (i_rx_dest_ip),
        .i_src_port  (i_rx_src_port),
        .i_dest_port (i_rx_dest_port),
        .i_length    (i_rx_length),
        .i_tvalid    (i_rx_tvalid),
        .o_tready    (o_rx_tready),
        .i_beat      (rx_beat),
        .hdr_q       (hdr_q[0]),
        .pay_q       (pay_q[0])
    );

    stream_fifo #(
        .T     (udp_reply_hdr_t),
        .DEPTH (`HDR_FIFO_DEPTH)
    ) hdr_fifo_i (
        .clk   (clk),
        .rst   (rst),
        .s_in  (hdr_q[0]),
        .s_out (hdr_q[1])
    );

    stream_fifo #(
        .T     (payload_beat_t),
        .DEPTH (`PAYLOAD_FIFO_DEPTH)
    ) pay_fifo_i (
        .clk   (clk),
        .rst   (rst),
        .s_in  (pay_q[0]),
        .s_out (pay_q[1])
    );

    udp_tx_sequencer tx_seq_i (
        .clk         (clk),
        .rst         (rst),
        .hdr_q       (hdr_q[1]),
        .pay_q       (pay_q[1]),
        .o_hdr_valid (o_tx_hdr_valid),
        .i_hdr_ready (i_tx_hdr_ready),
        .o_dest_ip   (o_tx_dest_ip),
        .o_src_port  (o_tx_src_port),
        .o_dest_port (o_tx_dest_port),
        .o_length    (o_tx_length),
        .o_tvalid    (o_tx_tvalid),
        .i_tready    (i_tx_tready),
        .o_beat      (tx_beat)
    );

endmodule

// File: test/tb_udp_echo_tasks.svh
// --------------------------------------
// Frame drivers and reply checks, used inside tb_udp_echo only
// --------------------------------------

task automatic report_error(input string msg);
    errors++;
    $display("** Error at %0t ns: %s", $time, msg);
    $display("Something failed");
    $fatal(1, "stopped at first error");
endtask

task automatic check_header();
    udp_reply_hdr_t got;
    udp_reply_hdr_t exp;
    got = {o_tx_dest_ip, o_tx_src_port, o_tx_dest_port, o_tx_length};
    assert (exp_hdr_q.size() != 0 && !in_frame)
        else report_error("reply header that no pending frame asked for");
    exp = exp_hdr_q.pop_front();
    assert (got == exp)
        else report_error($sformatf("header %h, expected %h", got, exp));
    hdr_count++;
    in_frame = 1'b1;
endtask

task automatic check_beat();
    payload_beat_t got;
    payload_beat_t exp;
    got = {o_tx_tdata, o_tx_tlast, o_tx_tuser};
    assert (exp_beat_q.size() != 0 && in_frame)
        else report_error("payload beat outside a reply frame");
    exp = exp_beat_q.pop_front();
    assert (got == exp)
        else report_error($sformatf("beat %h, expected %h", got, exp));
    beat_count++;
    in_frame = !got.last;
endtask

// Offers one header and its payload; echoed frames queue their expected reply
task automatic send_frame(input udp_port_t dest_port, input int nbytes);
    udp_reply_hdr_t exp;
    payload_beat_t  beat;
    ip_addr_t       src_ip;
    udp_port_t      src_port;
    logic           echoed;
    src_ip   = ip_addr_t'($urandom);
    src_port = udp_port_t'($urandom_range(1024, 65535));
    echoed   = (dest_port == `UDP_ECHO_PORT);
    // Back to the sender, ports swapped, length kept
    exp = {src_ip, dest_port, src_port, udp_len_t'(nbytes + 8)};
    if (echoed) begin
        exp_hdr_q.push_back(exp);
    end
    @(posedge clk);
    i_rx_hdr_valid <= 1'b1;
    i_rx_src_ip    <= src_ip;
    i_rx_dest_ip   <= ip_addr_t'($urandom);
    i_rx_src_port  <= src_port;
    i_rx_dest_port <= dest_port;
    i_rx_length    <= udp_len_t'(nbytes + 8);
    @(posedge clk);
    while (!o_rx_hdr_ready) begin
        @(posedge clk);
    end
    i_rx_hdr_valid <= 1'b0;
    for (int i = 0; i < nbytes; i++) begin
        beat = {`UDP_DATA_W'($urandom), i == nbytes - 1, 1'($urandom_range(0, 1))};
        if (echoed) begin
            exp_beat_q.push_back(beat);
        end
        i_rx_tvalid <= 1'b1;
        i_rx_tdata  <= beat.data;
        i_rx_tlast  <= beat.last;
        i_rx_tuser  <= beat.user;
        @(posedge clk);
        while (!o_rx_tready) begin
            @(posedge clk);
        end
    end
    i_rx_tvalid <= 1'b0;
endtask

task automatic wait_drain();
    while (exp_hdr_q.size() != 0 || exp_beat_q.size() != 0) begin
        @(posedge clk);
    end
endtask

task automatic test_reset_state();
    @(posedge clk);
    assert (!o_tx_hdr_valid && !o_tx_tvalid)
        else report_error("transmit valid high right after reset");
    assert (!o_rx_tready)
        else report_error("receive payload ready high before any header");
endtask

task automatic test_echo();
    int hdrs;
    hdrs = hdr_count;
    send_frame(`UDP_ECHO_PORT, 12);
    wait_drain();
    assert (hdr_count == hdrs + 1)
        else report_error("echo frame did not give exactly one reply");
endtask

task automatic test_drop();
    int hdrs;
    int beats;
    hdrs  = hdr_count;
    beats = beat_count;
    send_frame(16'd80, 6);
    repeat (50) @(posedge clk);
    assert (hdr_count == hdrs && beat_count == beats)
        else report_error("frame to port 80 produced output");
    send_frame(`UDP_ECHO_PORT, 5);
    wait_drain();
endtask

task automatic test_back_pressure();
    bit done;
    done = 1'b0;
    fork
        begin
            for (int f = 0; f < 6; f++) begin
                send_frame(`UDP_ECHO_PORT, 1 + $urandom_range(0, 15));
            end
            wait_drain();
            done = 1'b1;
        end
        while (!done) begin
            @(posedge clk);
            i_tx_hdr_ready <= 1'($urandom_range(0, 1));
            i_tx_tready    <= 1'($urandom_range(0, 1));
        end
    join
    @(posedge clk);
    i_tx_hdr_ready <= 1'b1;
    i_tx_tready    <= 1'b1;
endtask

// Header FIFO holds four replies, so the fifth header must wait
task automatic test_queuing();
    int base;
    base = rx_hdr_count;
    @(posedge clk);
    i_tx_hdr_ready <= 1'b0;
    fork
        for (int f = 0; f < 5; f++) begin
            send_frame(`UDP_ECHO_PORT, 2);
        end
        begin
            while (rx_hdr_count != base + 4) begin
                @(posedge clk);
            end
            repeat (20) begin
                @(posedge clk);
                assert (!o_rx_hdr_ready)
                    else report_error("header accepted with the reply queue full");
            end
            assert (o_tx_hdr_valid && !o_tx_tvalid)
                else report_error("reply header not waiting at the transmit side");
            i_tx_hdr_ready <= 1'b1;
        end
    join
    wait_drain();
endtask

// File: test/tb_udp_echo.sv
// --------------------------------------
// Directed tests of the UDP echo top; stops at the first error
// --------------------------------------
`timescale 1ns/1ps

`include "udp_echo_settings.svh"

module tb_udp_echo
    import net_types_pkg::*;
    import stream_pkg::*;
();

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   i_rx_hdr_valid;
    logic                   o_rx_hdr_ready;
    ip_addr_t               i_rx_src_ip;
    ip_addr_t               i_rx_dest_ip;
    udp_port_t              i_rx_src_port;
    udp_port_t              i_rx_dest_port;
    udp_len_t               i_rx_length;
    logic                   i_rx_tvalid;
    logic                   o_rx_tready;
    logic [`UDP_DATA_W-1:0] i_rx_tdata;
    logic                   i_rx_tlast;
    logic                   i_rx_tuser;
    logic                   o_tx_hdr_valid;
    logic                   i_tx_hdr_ready;
    ip_addr_t               o_tx_dest_ip;
    udp_port_t              o_tx_src_port;
    udp_port_t              o_tx_dest_port;
    udp_len_t               o_tx_length;
    logic                   o_tx_tvalid;
    logic                   i_tx_tready;
    logic [`UDP_DATA_W-1:0] o_tx_tdata;
    logic                   o_tx_tlast;
    logic                   o_tx_tuser;

    // Replies still owed by the DUT, oldest first
    udp_reply_hdr_t exp_hdr_q[$];
    payload_beat_t  exp_beat_q[$];
    int             hdr_count = 0;
    int             beat_count = 0;
    int             rx_hdr_count = 0;
    int             cycles = 0;
    int             errors = 0;
    logic           in_frame = 1'b0;

    udp_echo_top dut_i (.*);

    always #4 clk = ~clk;

    `include "tb_udp_echo_tasks.svh"

    // Outputs are read before this edge updates them
    always @(posedge clk) begin
        if (!rst && o_tx_hdr_valid && i_tx_hdr_ready) begin
            check_header();
        end
        if (!rst && o_tx_tvalid && i_tx_tready) begin
            check_beat();
        end
        if (!rst && i_rx_hdr_valid && o_rx_hdr_ready) begin
            rx_hdr_count <= rx_hdr_count + 1;
        end
    end

    // Tests need well under 1000 cycles
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= 4000) begin
            $display("Timeout: the tests did not finish within 4000 cycles");
            $display("Something failed");
            $fatal(1, "timeout");
        end
    end

    initial begin
        void'($urandom(66744));
        rst            = 1'b1;
        i_rx_hdr_valid = 1'b0;
        i_rx_src_ip    = '0;
        i_rx_dest_ip   = '0;
        i_rx_src_port  = '0;
        i_rx_dest_port = '0;
        i_rx_length    = '0;
        i_rx_tvalid    = 1'b0;
        i_rx_tdata     = '0;
        i_rx_tlast     = 1'b0;
        i_rx_tuser     = 1'b0;
        i_tx_hdr_ready = 1'b1;
        i_tx_tready    = 1'b1;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        test_reset_state();
        test_echo();
        test_drop();
        test_back_pressure();
        test_queuing();
        repeat (10) @(posedge clk);
        if (errors == 0 && exp_hdr_q.size() == 0 && exp_beat_q.size() == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+include
+incdir+test
hw/net_types_pkg.sv
hw/stream_pkg.sv
hw/stream_if.sv
hw/stream_fifo.sv
hw/udp_rx_filter.sv
hw/udp_tx_sequencer.sv
hw/udp_echo_top.sv
test/tb_udp_echo.sv

// File: Makefile
# Verilator build and run of the UDP echo testbench

TOP := tb_udp_echo
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build and run the testbench, pass if the log holds the pass line"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) 2>&1 | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
